/* Bender.yml */
package:
  name: ilk_crc24_engine

sources:
  - src/ilk_crc_pkg.sv
  - src/crc24_word_stage.sv
  - src/crc24_burst_ctrl.sv
  - src/crc24_multi_combine.sv
  - src/ilk_crc24_engine.sv
  - target: test
    files:
      - verification/ilk_crc24_engine_sva.sv
      - verification/ilk_crc24_engine_tb.sv

/* ilk_crc24_engine.f */
src/ilk_crc_pkg.sv
src/crc24_word_stage.sv
src/crc24_burst_ctrl.sv
src/crc24_multi_combine.sv
src/ilk_crc24_engine.sv
verification/ilk_crc24_engine_sva.sv
verification/ilk_crc24_engine_tb.sv

/* src/crc24_burst_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

// packet bookkeeping around the combiner
// it decides how many earlier words the current one joins, keeps the raw crc
// of the word before and the packet crc from two words back, and carries eop
// along the combiner pipeline to the output handshake
module crc24_burst_ctrl (
	input logic clk,
	input logic arst,
	input logic ena,
	input logic raw_valid,
	input ilk_crc_pkg::raw_crc_s raw,
	output ilk_crc_pkg::crc24_t cur_raw,
	output ilk_crc_pkg::crc24_t prev_raw,
	output ilk_crc_pkg::crc24_t roll_crc,
	output ilk_crc_pkg::covered_t covered,
	output logic comb_valid,
	input ilk_crc_pkg::crc24_t comb_crc,
	output ilk_crc_pkg::crc24_t crc,
	output logic crc_valid
);

	import ilk_crc_pkg::*;

	// covered value given to the last valid word
	covered_t cnt;
	covered_t cov_next;

	// raw crc of the last valid word
	crc24_t prev_q;

	// packet crc one result behind the combiner output
	crc24_t roll_q;

	// valid and eop, delayed to line up with the combiner stages
	logic v_d1;
	logic eop_d1;
	logic eop_d2;

	crc24_t crc_q;

	////////////////////
	// word coverage
	////////////////////

	// sop starts from nothing, after that each word covers one more earlier
	// word until the count sits at two, where the rolling crc takes over
	always_comb begin
		if (raw.sop) begin
			cov_next = '0;
		end else if (cnt == COVERED_MAX) begin
			cov_next = COVERED_MAX;
		end else begin
			cov_next = cnt + 2'd1;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			cnt <= '0;
		end else if (ena && raw_valid) begin
			cnt <= cov_next;
		end
	end

	////////////////////
	// word history
	////////////////////

	always_ff @(posedge clk) begin
		if (ena && raw_valid) begin
			prev_q <= raw.crc;
		end
	end

	// the combiner writes a new result on every edge where v_d1 is set
	// catching its old value on that same edge leaves roll_q exactly one
	// result behind, i.e. the crc two words before the one now in flight
	always_ff @(posedge clk) begin
		if (ena && v_d1) begin
			roll_q <= comb_crc;
		end
	end

	assign cur_raw = raw.crc;
	assign prev_raw = prev_q;
	assign roll_crc = roll_q;
	assign covered = cov_next;
	assign comb_valid = raw_valid;

	////////////////////
	// eop to output
	////////////////////

	// eop_d1 matches the first combiner register, eop_d2 the result register
	// crc_valid then drops on the first enabled edge, which is the one where
	// crc_ready took the result
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			v_d1 <= 1'b0;
			eop_d1 <= 1'b0;
			eop_d2 <= 1'b0;
			crc_valid <= 1'b0;
		end else if (ena) begin
			v_d1 <= raw_valid;
			eop_d1 <= raw_valid & raw.eop;
			eop_d2 <= eop_d1;
			crc_valid <= eop_d2;
		end
	end

	// finished packet crc, frozen by the enable while the output waits
	always_ff @(posedge clk) begin
		if (ena && eop_d2) begin
			crc_q <= comb_crc;
		end
	end

	assign crc = crc_q;

endmodule

`default_nettype wire

/* src/crc24_multi_combine.sv */
`default_nettype none
`timescale 1ns/10ps

// folds up to three contributions into the packet crc of word k
//   raw crc of word k
//   raw crc of word k-1 pushed past one zero word
//   either the evolved all ones seed or the packet crc of word k-2 pushed
//   past two zero words
// the result only feeds back through the two word old term, so there is
// never a crc loop closing within one cycle
module crc24_multi_combine (
	input logic clk,
	input logic arst,
	input logic ena,
	input logic valid,
	input ilk_crc_pkg::covered_t covered,
	input ilk_crc_pkg::crc24_t cur_raw,
	input ilk_crc_pkg::crc24_t prev_raw,
	input ilk_crc_pkg::crc24_t roll_crc,
	output ilk_crc_pkg::crc24_t crc_out
);

	import ilk_crc_pkg::*;

	crc24_t prev_evo;
	crc24_t roll_evo;
	logic include_prev;

	// first stage registers
	covered_t last_covered;
	logic last_valid;
	crc24_t cur_q;
	crc24_t prev_q;

	// oldest term, chosen after the first stage
	crc24_t oldest_term;

	////////////////////
	// evolutions
	////////////////////

	assign prev_evo = crc24_advance(prev_raw, 1);
	assign roll_evo = crc24_advance(roll_crc, 2);

	// word k-1 only counts when it belongs to this packet
	assign include_prev = (covered != '0);

	////////////////////
	// first stage
	////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			last_covered <= '0;
			last_valid <= 1'b0;
		end else if (ena) begin
			last_covered <= covered;
			last_valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ena) begin
			cur_q <= cur_raw;
			prev_q <= include_prev ? prev_evo : '0;
		end
	end

	////////////////////
	// oldest term
	////////////////////

	// this path skips the first register, roll_crc is only ready after the
	// previous result has landed, one cycle after the other inputs
	always_comb begin
		case (last_covered)
			2'd0: oldest_term = EVO1_INIT;
			2'd1: oldest_term = EVO2_INIT;
			2'd2: oldest_term = roll_evo;
			// an out of range count takes the seed three words back
			default: oldest_term = EVO3_INIT;
		endcase
	end

	////////////////////
	// result
	////////////////////

	// bubbles leave the running crc alone
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc_out <= CRC24_INIT;
		end else if (ena && last_valid) begin
			crc_out <= cur_q ^ prev_q ^ oldest_term;
		end
	end

endmodule

`default_nettype wire

/* src/crc24_word_stage.sv */
`default_nettype none
`timescale 1ns/10ps

// first pipeline stage
// every accepted word is reduced to its own crc, computed as if the packet
// started at that word with a zero register, so no word depends on another
// and the combiner further down can stitch them together
module crc24_word_stage (
	input logic clk,
	input logic arst,
	input logic ena,
	input logic in_valid,
	input ilk_crc_pkg::ilk_word_s in_word,
	output ilk_crc_pkg::raw_crc_s raw,
	output logic raw_valid
);

	import ilk_crc_pkg::*;

	// high on the edge that actually takes a word
	logic take;

	// raw crc of the word on the input, before the register
	raw_crc_s raw_next;

	assign take = ena & in_valid;

	////////////////////
	// raw crc
	////////////////////

	// the whole 64 bit word is folded in one go from a zero seed
	// sop and eop ride along untouched so later stages know the packet edges
	always_comb begin
		raw_next.crc = crc24_raw(in_word.data);
		raw_next.sop = in_word.sop;
		raw_next.eop = in_word.eop;
	end

	////////////////////
	// registers
	////////////////////

	// the valid bit follows the input on every enabled edge, so an empty
	// input cycle turns into a bubble one stage later
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			raw_valid <= 1'b0;
		end else if (ena) begin
			raw_valid <= in_valid;
		end
	end

	// the crc and flags only load on a real transfer
	// between words they keep the last value and raw_valid marks them stale
	always_ff @(posedge clk) begin
		if (take) begin
			raw <= raw_next;
		end
	end

endmodule

`default_nettype wire

/* src/ilk_crc24_engine.sv */
`default_nettype none
`timescale 1ns/10ps

// crc24 engine for packets of full 64 bit words
// word stage -> burst control <-> combiner, all moving on one enable
module ilk_crc24_engine (
	input logic clk,
	input logic arst,
	input ilk_crc_pkg::ilk_word_s word,
	input logic word_valid,
	output logic word_ready,
	output ilk_crc_pkg::crc24_t crc,
	output logic crc_valid,
	input logic crc_ready
);

	import ilk_crc_pkg::*;

	// set on the first edge after reset, keeps the pipeline and word_ready
	// quiet while reset is applied
	logic running;
	logic ena;

	raw_crc_s raw;
	logic raw_valid;

	crc24_t cur_raw;
	crc24_t prev_raw;
	crc24_t roll_crc;
	covered_t covered;
	logic comb_valid;
	crc24_t comb_crc;

	////////////////////
	// advance enable
	////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	// a waiting result stops every stage at once, nothing is dropped
	assign ena = running & (~crc_valid | crc_ready);
	assign word_ready = ena;

	////////////////////
	// stages
	////////////////////

	crc24_word_stage u_word_stage (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.in_valid(word_valid),
		.in_word(word),
		.raw(raw),
		.raw_valid(raw_valid)
	);

	crc24_burst_ctrl u_burst_ctrl (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.raw_valid(raw_valid),
		.raw(raw),
		.cur_raw(cur_raw),
		.prev_raw(prev_raw),
		.roll_crc(roll_crc),
		.covered(covered),
		.comb_valid(comb_valid),
		.comb_crc(comb_crc),
		.crc(crc),
		.crc_valid(crc_valid)
	);

	crc24_multi_combine u_combine (
		.clk(clk),
		.arst(arst),
		.ena(ena),
		.valid(comb_valid),
		.covered(covered),
		.cur_raw(cur_raw),
		.prev_raw(prev_raw),
		.roll_crc(roll_crc),
		.crc_out(comb_crc)
	);

endmodule

`default_nettype wire

/* src/ilk_crc_pkg.sv */
`default_nettype none

package ilk_crc_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int DATA_W = 64;
	localparam int CRC_W = 24;
	localparam int COVERED_W = 2;

	// the evolution function never has to look further than three words back
	localparam int MAX_ADVANCE = 3;

	typedef logic [CRC_W-1:0] crc24_t;
	typedef logic [DATA_W-1:0] word64_t;
	typedef logic [COVERED_W-1:0] covered_t;

	// count of earlier words folded into a result, it saturates here
	localparam covered_t COVERED_MAX = 2'd2;

	// interlaken crc24, no reflection and no final inversion
	localparam crc24_t CRC24_POLY = 24'h328B63;
	localparam crc24_t CRC24_INIT = 24'hFFFFFF;

	////////////////////
	// stream records
	////////////////////

	typedef struct packed {
		word64_t data;
		logic sop;
		logic eop;
	} ilk_word_s;

	typedef struct packed {
		crc24_t crc;
		logic sop;
		logic eop;
	} raw_crc_s;

	////////////////////
	// crc arithmetic
	////////////////////

	// push a crc through a number of all zero 64 bit words
	// the word count is a constant at every call, so the unused passes fold away
	function automatic crc24_t crc24_advance(crc24_t crc, int unsigned words);
		crc24_t c;
		logic fb;
		c = crc;
		for (int w = 0; w < MAX_ADVANCE; w++) begin
			if (w < words) begin
				for (int b = 0; b < DATA_W; b++) begin
					fb = c[CRC_W-1];
					c = {c[CRC_W-2:0], 1'b0};
					if (fb) begin
						c = c ^ CRC24_POLY;
					end
				end
			end
		end
		return c;
	endfunction

	// crc of a single word starting from zero, msb of the word goes in first
	function automatic crc24_t crc24_raw(word64_t data);
		crc24_t c;
		logic fb;
		c = '0;
		for (int b = DATA_W - 1; b >= 0; b--) begin
			fb = c[CRC_W-1] ^ data[b];
			c = {c[CRC_W-2:0], 1'b0};
			if (fb) begin
				c = c ^ CRC24_POLY;
			end
		end
		return c;
	endfunction

	// the all ones seed seen one, two and three words later
	localparam crc24_t EVO1_INIT = crc24_advance(CRC24_INIT, 1);
	localparam crc24_t EVO2_INIT = crc24_advance(CRC24_INIT, 2);
	localparam crc24_t EVO3_INIT = crc24_advance(CRC24_INIT, 3);

endpackage

`default_nettype wire

/* verification/ilk_crc24_engine_sva.sv */
`default_nettype none
`timescale 1ns/10ps

// protocol checks on the engine boundary, bound into every engine instance
module ilk_crc24_engine_sva (
	input logic clk,
	input logic arst,
	input ilk_crc_pkg::crc24_t crc,
	input logic crc_valid,
	input logic crc_ready,
	input logic word_ready
);

	////////////////////
	// output handshake
	////////////////////

	// a result that is not taken must wait unchanged for the next edge
	crc_held : assert property (
		@(posedge clk) disable iff (arst)
		(crc_valid && !crc_ready) |=> (crc_valid && $stable(crc))
	) else $error("crc changed or crc_valid dropped while waiting for crc_ready");

	// an offered result is always a defined value
	crc_known : assert property (
		@(posedge clk) disable iff (arst)
		crc_valid |-> !$isunknown(crc)
	) else $error("crc holds unknown bits while crc_valid is high");

	////////////////////
	// reset state
	////////////////////

	// while reset is applied the engine neither offers a result nor takes a word
	reset_quiet : assert property (
		@(posedge clk) arst |-> (!crc_valid && !word_ready)
	) else $error("crc_valid or word_ready is high during reset");

endmodule

bind ilk_crc24_engine ilk_crc24_engine_sva u_sva (
	.clk(clk),
	.arst(arst),
	.crc(crc),
	.crc_valid(crc_valid),
	.crc_ready(crc_ready),
	.word_ready(word_ready)
);

`default_nettype wire

/* verification/ilk_crc24_engine_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module ilk_crc24_engine_tb;

	import ilk_crc_pkg::*;

	localparam int MAX_ROWS = 64;
	localparam int MAX_PKTS = 32;
	localparam int CYCLES_PER_WORD = 20;
	localparam int MARGIN_CYCLES = 500;
	localparam int PERIOD_NS = 4;
	localparam logic [31:0] SEED = 32'd73819;

	logic clk;
	logic arst;
	ilk_word_s word;
	logic word_valid;
	logic word_ready;
	crc24_t crc;
	logic crc_valid;
	logic crc_ready;

	// one row per word holds the expected crc, the flags (8 end, 2 sop, 1 eop) and the data
	logic [91:0] rows [0:MAX_ROWS-1];
	word64_t w_data [0:MAX_ROWS-1];
	logic w_sop [0:MAX_ROWS-1];
	logic w_eop [0:MAX_ROWS-1];
	int pkt_first [0:MAX_PKTS-1];
	int pkt_len [0:MAX_PKTS-1];
	crc24_t model_crc [0:MAX_PKTS-1];

	int n_words;
	int n_packets;
	int got_count;
	int phase;
	int errors;
	int checks;
	int limit_ns;
	logic loaded;
	logic gap_mode;
	logic stall_mode;
	logic [31:0] gap_state;
	logic [31:0] rdy_state;

	ilk_crc24_engine uut (
		.clk(clk),
		.arst(arst),
		.word(word),
		.word_valid(word_valid),
		.word_ready(word_ready),
		.crc(crc),
		.crc_valid(crc_valid),
		.crc_ready(crc_ready)
	);

	initial clk = 1'b0;
	always #(PERIOD_NS / 2) clk = ~clk;

	////////////////////
	// helpers
	////////////////////

	// right shifting galois lfsr where the bit taken is the one shifted out
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'hB4BCD35C;
		end
		return n;
	endfunction

	task automatic draw_bit(inout logic [31:0] state, output logic b);
		b = state[0];
		state = lfsr_step(state);
	endtask

	// bit serial crc24 over one word msb first from a given register value
	function automatic crc24_t serial_word(crc24_t start, word64_t data);
		crc24_t c;
		logic fb;
		c = start;
		for (int i = 63; i >= 0; i--) begin
			fb = c[23] ^ data[i];
			c = {c[22:0], 1'b0};
			if (fb) begin
				c = c ^ CRC24_POLY;
			end
		end
		return c;
	endfunction

	task automatic check_crc(input string name, input crc24_t got, input crc24_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_latency(input string name, input int got, input int expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
		end
	endtask

	// offers one word with a random idle gap first when gaps are on
	// returns 1 ns after the edge that took the word and leaves word_valid high
	task automatic drive_word(input int idx);
		logic took;
		logic b0;
		logic b1;
		int n_idle;
		n_idle = 0;
		if (gap_mode) begin
			draw_bit(gap_state, b0);
			draw_bit(gap_state, b1);
			if (b0 && b1) begin
				n_idle = 3;
			end else if (b0) begin
				n_idle = 1;
			end
		end
		if (n_idle > 0) begin
			word_valid = 1'b0;
			repeat (n_idle) begin
				@(posedge clk);
				#1;
			end
		end
		word = '{data: w_data[idx], sop: w_sop[idx], eop: w_eop[idx]};
		word_valid = 1'b1;
		took = 1'b0;
		while (!took) begin
			// ready and valid are both settled at the falling edge
			@(negedge clk);
			took = word_ready;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_packet(input int p);
		for (int i = pkt_first[p]; i < pkt_first[p] + pkt_len[p]; i++) begin
			drive_word(i);
		end
	endtask

	// waits for every packet of the phase and then for stray extra results
	task automatic finish_phase();
		word_valid = 1'b0;
		while (got_count < n_packets) begin
			@(posedge clk);
			#1;
		end
		repeat (10) begin
			@(posedge clk);
			#1;
		end
		check_count("result count", got_count, n_packets);
	endtask

	////////////////////
	// output side
	////////////////////

	// crc_ready is driven just after each rising edge and is low a quarter
	// of the time while stalls are on
	always @(posedge clk) begin : ready_driver
		logic b0;
		logic b1;
		#1;
		if (stall_mode) begin
			draw_bit(rdy_state, b0);
			draw_bit(rdy_state, b1);
			crc_ready = b0 | b1;
		end else begin
			crc_ready = 1'b1;
		end
	end

	// valid and ready high at the falling edge mean a transfer on the next rise
	always @(negedge clk) begin
		if (!arst && crc_valid && crc_ready) begin
			if (got_count < n_packets) begin
				check_crc("crc", crc, model_crc[got_count]);
				$display("phase %0d packet %0d: crc %h expected %h", phase, got_count, crc,
					model_crc[got_count]);
			end else begin
				errors++;
				$display("phase %0d: the engine gave a result with no packet left", phase);
			end
			got_count++;
		end
	end

	////////////////////
	// watchdog
	////////////////////

	initial begin
		wait (loaded);
		#(limit_ns);
		$display("timeout: the run did not end within %0d ns", limit_ns);
		$display("Errors found");
		$finish;
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin : main
		crc24_t run;
		int lat;
		arst = 1'b1;
		word = '0;
		word_valid = 1'b0;
		crc_ready = 1'b1;
		gap_mode = 1'b0;
		stall_mode = 1'b0;
		gap_state = SEED;
		rdy_state = SEED;
		errors = 0;
		checks = 0;
		got_count = 0;
		phase = 0;
		loaded = 1'b0;
		n_words = 0;
		n_packets = 0;

		// unused rows read as end markers
		for (int i = 0; i < MAX_ROWS; i++) begin
			rows[i] = {24'h0, 4'h8, 64'h0};
		end
		$readmemh("verification/ilk_crc24_stimulus.txt", rows);

		// split the rows into packets and recompute every expected crc
		run = CRC24_INIT;
		while (n_words < MAX_ROWS && !rows[n_words][67]) begin
			w_data[n_words] = rows[n_words][63:0];
			w_sop[n_words] = rows[n_words][65];
			w_eop[n_words] = rows[n_words][64];
			if (w_sop[n_words]) begin
				run = CRC24_INIT;
				pkt_first[n_packets] = n_words;
			end
			run = serial_word(run, w_data[n_words]);
			if (w_eop[n_words]) begin
				model_crc[n_packets] = run;
				pkt_len[n_packets] = n_words - pkt_first[n_packets] + 1;
				check_crc("file crc", rows[n_words][91:68], run);
				n_packets++;
			end
			n_words++;
		end
		if (n_packets == 0) begin
			errors++;
			$display("the stimulus file holds no complete packet");
		end

		// three passes over the file with a generous budget for each word
		limit_ns = (3 * n_words * CYCLES_PER_WORD + MARGIN_CYCLES) * PERIOD_NS;
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#1;
		arst = 1'b0;
		@(posedge clk);
		#1;

		// phase 0 sends one packet at a time into an idle engine and times eop
		phase = 0;
		got_count = 0;
		for (int p = 0; p < n_packets; p++) begin
			send_packet(p);
			word_valid = 1'b0;
			lat = 0;
			do begin
				@(posedge clk);
				lat++;
				#1;
			end while (!crc_valid && lat < 8);
			if (!crc_valid) begin
				errors++;
				$display("packet %0d: crc_valid never rose after eop", p);
			end
			check_latency("crc_valid latency", lat, 3);
			while (got_count < p + 1) begin
				@(posedge clk);
				#1;
			end
		end
		finish_phase();

		// phase 1 streams every packet back to back with sop right after eop
		phase = 1;
		got_count = 0;
		for (int p = 0; p < n_packets; p++) begin
			send_packet(p);
		end
		finish_phase();

		// phase 2 repeats the stream with input gaps and crc_ready stalls
		phase = 2;
		got_count = 0;
		gap_mode = 1'b1;
		stall_mode = 1'b1;
		for (int p = 0; p < n_packets; p++) begin
			send_packet(p);
		end
		finish_phase();
		stall_mode = 1'b0;

		$display("checks %0d, errors %0d, packets per phase %0d", checks, errors, n_packets);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/ilk_crc24_stimulus.txt */
// columns: expected crc (eop rows, else zero) _ flags (8 end, 2 sop, 1 eop) _ data word
// one row per word in stream order, the last row marks the end of the file
F8A6EF_3_FFFFFF0000000005
6CFDF7_3_FFFFFF000000000C
000000_2_FFFFFF0000000001
C3C6BD_1_328B63000000000A
000000_2_FFFFFF0000000007
09EB31_1_9DB029000000000E
000000_2_FFFFFF0000000002
000000_0_6516C60000000009
CA2D8C_1_945B180000000004
000000_2_FFFFFF000000000B
000000_0_F14DDE0000000003
000000_0_579DA5000000000D
AF3B4A_1_5E76940000000006
000000_2_FFFFFF0000000008
000000_0_A6D07B000000000F
000000_0_3B60520000000001
000000_0_328B63000000000C
F8A6EF_1_6CFDF70000000005
000000_2_FFFFFF0000000003
000000_0_579DA50000000006
000000_0_AF3B4A0000000009
000000_0_945B18000000000C
000000_0_6CFDF7000000000F
000000_0_3B60520000000002
000000_0_6516C60000000005
A6D07B_1_F8A6EF0000000008
000000_8_0000000000000000
